// ==== iagc_canceller.f ====
logic/iagc_pkg.sv
logic/error_former.sv
logic/phase_detector.sv
logic/level_detector.sv
logic/weight_controller.sv
logic/iagc_canceller.sv
test/iagc_canceller_sva.sv
test/iagc_canceller_tb.sv

// ==== Bender.yml ====
package:
  name: iagc_canceller

sources:
  - logic/iagc_pkg.sv
  - logic/error_former.sv
  - logic/phase_detector.sv
  - logic/level_detector.sv
  - logic/weight_controller.sv
  - logic/iagc_canceller.sv
  - target: test
    files:
      - test/iagc_canceller_sva.sv
      - test/iagc_canceller_tb.sv

// ==== test/iagc_canceller_tb.sv ====
`default_nettype none

module iagc_canceller_tb;

    // qualified samples can be sparse when the gate stays low
    localparam int WORST_WINDOW = iagc_pkg::WINDOW_SAMPLES * 16;
    localparam int CYCLE_LIMIT  = 40 * WORST_WINDOW + 200;

    logic                                     clock = 1'b0;
    logic                                     arst_n = 1'b0;
    logic                                     enable = 1'b0;
    logic                                     sample = 1'b0;
    logic                                     gate = 1'b0;
    logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] input_value = '0;
    logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] reference_value = '0;
    logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] error_value;
    logic                                     error_valid;
    logic signed [iagc_pkg::WEIGHT_WIDTH-1:0] weight;
    iagc_pkg::iagc_status_e                   status;
    logic                                     locked;

    logic                                     enable_q = 1'b0;
    logic                                     gate_q = 1'b0;
    logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] reference_q = '0;
    logic [31:0]                              lfsr = 32'haf2c;

    iagc_pkg::iagc_status_e model_status = iagc_pkg::IAGC_RESET;
    int                     model_weight = 0;
    logic                   model_locked = 1'b0;
    int                     next_weight = 0;
    logic                   next_locked = 1'b0;
    int                     pending = 0;
    int                     count = 0;
    int                     agree = 0;
    int                     disagree = 0;
    int                     sum = 0;
    int                     decisions = 0;
    int                     cycles = 0;
    int                     value_errors = 0;
    int                     other_errors = 0;
    logic                   seen_lock = 1'b0;

    iagc_canceller dut0 (
        .i_clock       (clock),
        .i_arst_n      (arst_n),
        .i_enable      (enable),
        .i_sample      (sample),
        .i_gate        (gate),
        .i_input       (input_value),
        .i_reference   (reference_value),
        .o_error       (error_value),
        .o_error_valid (error_valid),
        .o_weight      (weight),
        .o_status      (status),
        .o_locked      (locked)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        value_errors++;
        $display("** Error %s: expected %0d, actual %0d", test, expected, actual);
    endtask

    // mode 0 ratio 1/64, mode 1 ratio 3/8, mode 2 ratio -1/64
    // modes 3 and 4 ratio 6 and -6 on dense samples
    task automatic drive_samples(input int mode, input int windows);
        logic [31:0]                              bits;
        logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] noise;
        int                                       target;
        target = decisions + windows;
        while (decisions < target) begin
            @(posedge clock);
            #1;
            enable = 1'b1;
            take_bits(2, bits);
            sample = bits[1:0] != 2'b00;
            take_bits(4, bits);
            if (bits[3:0] == 4'h0) begin
                gate = !gate;  // gate comes in bursts
            end
            take_bits(14, bits);
            reference_value = bits[13:0];
            if (mode >= 3) begin
                sample          = 1'b1;  // short windows walk the weight to a bound
                gate            = 1'b1;
                reference_value = reference_value >>> 3;
            end
            take_bits(3, bits);
            noise = $signed(bits[2:0]);
            case (mode)
                0: input_value = (reference_value >>> 6) + noise;
                1: input_value = (reference_value >>> 2) + (reference_value >>> 3) + noise;
                2: input_value = noise - (reference_value >>> 6);
                3: input_value = reference_value * 6;
                default: input_value = -(reference_value * 6);
            endcase
            take_bits(5, bits);
            if (!gate && bits[4:0] == 5'h0) begin
                input_value = reference_value < 0 ? iagc_pkg::SAMPLE_MAX : iagc_pkg::SAMPLE_MIN;
            end
        end
    endtask

    task automatic idle_disabled(input int length);
        repeat (length) begin
            @(posedge clock);
            #1;
            enable = 1'b0;
            sample = 1'b0;
        end
    endtask

    task automatic predict_decision();
        int               step;
        iagc_pkg::level_e level;
        if ((sum >> iagc_pkg::WINDOW_LOG2) < int'(iagc_pkg::LEVEL_LOW_LIMIT)) begin
            level = iagc_pkg::LEVEL_LOW;
        end else if ((sum >> iagc_pkg::WINDOW_LOG2) >= int'(iagc_pkg::LEVEL_HIGH_LIMIT)) begin
            level = iagc_pkg::LEVEL_HIGH;
        end else begin
            level = iagc_pkg::LEVEL_MID;
        end
        step = level == iagc_pkg::LEVEL_HIGH ? int'(iagc_pkg::STEP_COARSE)
             : level == iagc_pkg::LEVEL_MID ? int'(iagc_pkg::STEP_FINE) : 0;
        next_weight = agree >= disagree ? model_weight + step : model_weight - step;
        if (next_weight > int'(iagc_pkg::WEIGHT_MAX)) begin
            next_weight = int'(iagc_pkg::WEIGHT_MAX);
        end else if (next_weight < int'(iagc_pkg::WEIGHT_MIN)) begin
            next_weight = int'(iagc_pkg::WEIGHT_MIN);
        end
        next_locked = level == iagc_pkg::LEVEL_LOW;
    endtask

    always @(posedge clock) begin
        enable_q    <= enable;
        gate_q      <= gate;
        reference_q <= reference_value;
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: windows did not complete within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // window model, outputs are settled at the falling edge
    always @(negedge clock) begin
        if (!arst_n || !enable_q) begin
            model_status = iagc_pkg::IAGC_RESET;
            model_weight = 0;
            model_locked = 1'b0;
            pending      = 0;
        end else if (pending == 1) begin
            model_status = iagc_pkg::IAGC_INIT;
            model_weight = next_weight;
            model_locked = next_locked;
            pending      = 0;
            decisions++;
        end else if (pending == 2) begin
            pending = 1;  // done pulse on the detectors
        end else if (model_status == iagc_pkg::IAGC_RESET) begin
            model_status = iagc_pkg::IAGC_INIT;
        end else begin
            model_status = iagc_pkg::IAGC_ADAPT;
        end
        assert (status == model_status)
            else report_mismatch("status sequence", int'(model_status), int'(status));
        assert (int'(weight) == model_weight)
            else report_mismatch("window weight", model_weight, int'(weight));
        assert (locked == model_locked)
            else report_mismatch("lock flag", int'(model_locked), int'(locked));
        seen_lock = seen_lock || model_locked;
        if (model_status != iagc_pkg::IAGC_ADAPT) begin
            count    = 0;
            agree    = 0;
            disagree = 0;
            sum      = 0;
        end else if (pending == 0 && error_valid && gate_q) begin
            count++;
            if (error_value[iagc_pkg::SAMPLE_WIDTH-1] == reference_q[iagc_pkg::SAMPLE_WIDTH-1]) begin
                agree++;
            end else begin
                disagree++;
            end
            sum += error_value < 0 ? -int'(error_value) : int'(error_value);
            if (count == iagc_pkg::WINDOW_SAMPLES) begin
                predict_decision();
                pending = 2;
            end
        end
    end

    initial begin
        repeat (4) @(posedge clock);
        #1;
        arst_n = 1'b1;
        idle_disabled(3);
        drive_samples(0, 8);   // locks near a small weight and holds
        idle_disabled(3);
        drive_samples(1, 10);  // coarse steps then fine
        idle_disabled(3);
        drive_samples(2, 5);
        idle_disabled(3);
        drive_samples(3, 66);  // climbs to the upper weight bound and stays
        idle_disabled(3);
        drive_samples(4, 66);
        idle_disabled(2);
        if (!seen_lock) begin
            other_errors++;
            $display("the loop never locked");
        end
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, dut0.sva0.fail_count);
        if (value_errors + other_errors + dut0.sva0.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/iagc_canceller_sva.sv ====
`default_nettype none

module iagc_canceller_sva (
    input wire                                           i_clock,
    input wire                                           i_arst_n,
    input wire                                           i_enable,
    input wire                                           i_sample,
    input wire logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] i_input,
    input wire logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] i_reference,
    input wire logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] o_error,
    input wire                                           o_error_valid,
    input wire logic signed [iagc_pkg::WEIGHT_WIDTH-1:0] o_weight,
    input wire iagc_pkg::iagc_status_e                   o_status,
    input wire                                           o_locked,
    input wire iagc_pkg::phase_result_t                  i_phase,
    input wire iagc_pkg::level_result_t                  i_level
);

    int fail_count = 0;

    // saturated difference of input and scaled reference
    function automatic int expected_error(input int din, input int refv, input int w);
        int diff;
        diff = din - ((w * refv) >>> iagc_pkg::WEIGHT_FRAC);
        if (diff > int'(iagc_pkg::SAMPLE_MAX)) begin
            return int'(iagc_pkg::SAMPLE_MAX);
        end else if (diff < int'(iagc_pkg::SAMPLE_MIN)) begin
            return int'(iagc_pkg::SAMPLE_MIN);
        end
        return diff;
    endfunction

    reset_state: assert property (@(posedge i_clock) !i_arst_n |=> o_status == iagc_pkg::IAGC_RESET
        && o_weight == '0 && !o_locked && !o_error_valid)
        else begin
            fail_count++;
            $error("outputs not cleared by reset");
        end

    disabled_state: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !i_enable |=> o_status == iagc_pkg::IAGC_RESET && o_weight == '0 && !o_locked)
        else begin
            fail_count++;
            $error("loop not cleared while disabled");
        end

    valid_delay: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        1'b1 |=> o_error_valid == $past(i_sample))
        else begin
            fail_count++;
            $error("error valid does not follow the sample strobe");
        end

    error_forming: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_sample |=> o_error_valid && int'(o_error) == expected_error($past(i_input),
        $past(i_reference), $past(o_weight)))
        else begin
            fail_count++;
            $error("error sample wrong");
        end

    done_pair: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_phase.done == i_level.done)
        else begin
            fail_count++;
            $error("detector done pulses out of step");
        end

    done_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_phase.done |=> !i_phase.done)
        else begin
            fail_count++;
            $error("detector done lasted more than one cycle");
        end

    weight_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_enable && !(i_phase.done && i_level.done) |=> $stable(o_weight))
        else begin
            fail_count++;
            $error("weight moved without a decision");
        end

    restart: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_enable && o_status == iagc_pkg::IAGC_ADAPT && i_phase.done && i_level.done
        |=> o_status == iagc_pkg::IAGC_INIT
        && o_locked == ($past(i_level.level) == iagc_pkg::LEVEL_LOW))
        else begin
            fail_count++;
            $error("no restart after decision");
        end

    init_once: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_enable && o_status == iagc_pkg::IAGC_INIT |=> o_status == iagc_pkg::IAGC_ADAPT)
        else begin
            fail_count++;
            $error("init lasted more than one cycle");
        end

endmodule

bind iagc_canceller iagc_canceller_sva sva0 (.*, .i_phase(phase), .i_level(level));

`default_nettype wire

// ==== logic/iagc_canceller.sv ====
`default_nettype none

module iagc_canceller (
    input  wire                                        i_clock,
    input  wire                                        i_arst_n,
    input  wire                                        i_enable,
    input  wire                                        i_sample,
    input  wire                                        i_gate,
    input  wire logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] i_input,
    input  wire logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] i_reference,
    output logic signed [iagc_pkg::SAMPLE_WIDTH-1:0]   o_error,
    output logic                                       o_error_valid,
    output logic signed [iagc_pkg::WEIGHT_WIDTH-1:0]   o_weight,
    output iagc_pkg::iagc_status_e                     o_status,
    output logic                                       o_locked
);

    iagc_pkg::sample_t                        sample;
    iagc_pkg::phase_result_t                  phase;
    iagc_pkg::level_result_t                  level;
    iagc_pkg::iagc_status_e                   status;
    logic signed [iagc_pkg::WEIGHT_WIDTH-1:0] weight;

    error_former error_former0 (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_sample    (i_sample),
        .i_gate      (i_gate),
        .i_input     (i_input),
        .i_reference (i_reference),
        .i_weight    (weight),
        .o_sample    (sample)
    );

    phase_detector phase_detector0 (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_status (status),
        .i_sample (sample),
        .o_result (phase)
    );

    level_detector level_detector0 (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_status (status),
        .i_sample (sample),
        .o_result (level)
    );

    weight_controller weight_controller0 (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_enable (i_enable),
        .i_phase  (phase),
        .i_level  (level),
        .o_status (status),
        .o_weight (weight),
        .o_locked (o_locked)
    );

    // error output straight from the aligned sample
    assign o_error       = sample.error;
    assign o_error_valid = sample.valid;
    assign o_weight      = weight;
    assign o_status      = status;

endmodule

`default_nettype wire

// ==== logic/weight_controller.sv ====
`default_nettype none

module weight_controller (
    input  wire                                i_clock,
    input  wire                                i_arst_n,
    input  wire                                i_enable,
    input  wire iagc_pkg::phase_result_t       i_phase,
    input  wire iagc_pkg::level_result_t       i_level,
    output iagc_pkg::iagc_status_e             o_status,
    output logic signed [iagc_pkg::WEIGHT_WIDTH-1:0] o_weight,
    output logic                               o_locked
);

    iagc_pkg::iagc_status_e                        status;
    logic signed [iagc_pkg::WEIGHT_WIDTH-1:0]      weight;
    logic signed [iagc_pkg::WEIGHT_WIDTH-1:0]      weight_next;
    logic signed [iagc_pkg::WEIGHT_SUM_WIDTH-1:0]  step;
    logic signed [iagc_pkg::WEIGHT_SUM_WIDTH-1:0]  sum;
    logic                                          locked;
    logic                                          decide;

    // both verdicts of one window
    assign decide = status == iagc_pkg::IAGC_ADAPT && i_phase.done && i_level.done;

    // step size from level, direction from phase
    always_comb begin
        case (i_level.level)
            iagc_pkg::LEVEL_MID: begin
                step = iagc_pkg::WEIGHT_SUM_WIDTH'(iagc_pkg::STEP_FINE);
            end
            iagc_pkg::LEVEL_HIGH: begin
                step = iagc_pkg::WEIGHT_SUM_WIDTH'(iagc_pkg::STEP_COARSE);
            end
            default: begin
                step = '0;  // residual small, hold
            end
        endcase

        if (i_phase.in_phase) begin
            sum = iagc_pkg::WEIGHT_SUM_WIDTH'(weight) + step;
        end else begin
            sum = iagc_pkg::WEIGHT_SUM_WIDTH'(weight) - step;
        end

        if (sum > iagc_pkg::WEIGHT_SUM_WIDTH'(iagc_pkg::WEIGHT_MAX)) begin
            weight_next = iagc_pkg::WEIGHT_MAX;
        end else if (sum < iagc_pkg::WEIGHT_SUM_WIDTH'(iagc_pkg::WEIGHT_MIN)) begin
            weight_next = iagc_pkg::WEIGHT_MIN;
        end else begin
            weight_next = sum[iagc_pkg::WEIGHT_WIDTH-1:0];
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            status <= iagc_pkg::IAGC_RESET;
            weight <= '0;
            locked <= 1'b0;
        end else if (!i_enable) begin
            status <= iagc_pkg::IAGC_RESET;
            weight <= '0;
            locked <= 1'b0;
        end else begin
            case (status)
                iagc_pkg::IAGC_RESET: begin
                    status <= iagc_pkg::IAGC_INIT;
                end
                iagc_pkg::IAGC_INIT: begin
                    status <= iagc_pkg::IAGC_ADAPT;  // detectors start counting
                end
                iagc_pkg::IAGC_ADAPT: begin
                    if (decide) begin
                        weight <= weight_next;
                        locked <= i_level.level == iagc_pkg::LEVEL_LOW;
                        status <= iagc_pkg::IAGC_INIT;  // restart both windows
                    end
                end
                default: begin
                    status <= iagc_pkg::IAGC_RESET;
                end
            endcase
        end
    end

    assign o_status = status;
    assign o_weight = weight;
    assign o_locked = locked;

endmodule

`default_nettype wire

// ==== logic/level_detector.sv ====
`default_nettype none

module level_detector (
    input  wire                         i_clock,
    input  wire                         i_arst_n,
    input  wire iagc_pkg::iagc_status_e i_status,
    input  wire iagc_pkg::sample_t      i_sample,
    output iagc_pkg::level_result_t     o_result
);

    iagc_pkg::det_state_e              state;
    logic [iagc_pkg::COUNT_WIDTH-1:0]  samples;
    logic [iagc_pkg::SUM_WIDTH-1:0]    sum;
    logic [iagc_pkg::SUM_WIDTH-1:0]    sum_next;
    logic [iagc_pkg::SAMPLE_WIDTH-1:0] magnitude;
    logic [iagc_pkg::SAMPLE_WIDTH-1:0] mean;
    logic                              qualified;
    logic                              last;
    logic                              done;
    iagc_pkg::level_e                  level;
    iagc_pkg::level_e                  level_next;

    assign qualified = i_sample.valid && i_sample.gate;

    // most negative sample still fits as unsigned
    assign magnitude = i_sample.error[iagc_pkg::SAMPLE_WIDTH-1]
                       ? $unsigned(-i_sample.error) : $unsigned(i_sample.error);

    assign sum_next = sum + (qualified ? iagc_pkg::SUM_WIDTH'(magnitude) : '0);
    assign mean     = sum_next[iagc_pkg::SUM_WIDTH-1:iagc_pkg::WINDOW_LOG2];

    assign last = qualified
                  && samples == iagc_pkg::COUNT_WIDTH'(iagc_pkg::WINDOW_SAMPLES - 1);

    always_comb begin
        if (mean < iagc_pkg::LEVEL_LOW_LIMIT) begin
            level_next = iagc_pkg::LEVEL_LOW;
        end else if (mean >= iagc_pkg::LEVEL_HIGH_LIMIT) begin
            level_next = iagc_pkg::LEVEL_HIGH;
        end else begin
            level_next = iagc_pkg::LEVEL_MID;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= iagc_pkg::DET_CLEAR;
            samples <= '0;
            sum     <= '0;
            done    <= 1'b0;
            level   <= iagc_pkg::LEVEL_LOW;
        end else if (i_status != iagc_pkg::IAGC_ADAPT) begin
            state   <= iagc_pkg::DET_CLEAR;
            samples <= '0;
            sum     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state != iagc_pkg::DET_REPORT) begin
                samples <= samples + iagc_pkg::COUNT_WIDTH'(qualified);
                sum     <= sum_next;
                if (last) begin
                    state <= iagc_pkg::DET_REPORT;
                    done  <= 1'b1;
                    level <= level_next;
                end else if (qualified) begin
                    state <= iagc_pkg::DET_COUNT;
                end
            end
        end
    end

    assign o_result = '{done: done, level: level};

endmodule

`default_nettype wire

// ==== logic/phase_detector.sv ====
`default_nettype none

module phase_detector (
    input  wire                         i_clock,
    input  wire                         i_arst_n,
    input  wire iagc_pkg::iagc_status_e i_status,
    input  wire iagc_pkg::sample_t      i_sample,
    output iagc_pkg::phase_result_t     o_result
);

    iagc_pkg::det_state_e             state;
    logic [iagc_pkg::COUNT_WIDTH-1:0] samples;
    logic [iagc_pkg::COUNT_WIDTH-1:0] agree_count;
    logic [iagc_pkg::COUNT_WIDTH-1:0] disagree_count;
    logic [iagc_pkg::COUNT_WIDTH-1:0] agree_next;
    logic [iagc_pkg::COUNT_WIDTH-1:0] disagree_next;
    logic                             qualified;
    logic                             agree;
    logic                             last;
    logic                             done;
    logic                             in_phase;

    assign qualified = i_sample.valid && i_sample.gate;

    // sign bits equal
    assign agree = i_sample.reference[iagc_pkg::SAMPLE_WIDTH-1]
                   == i_sample.error[iagc_pkg::SAMPLE_WIDTH-1];

    assign agree_next    = agree_count + iagc_pkg::COUNT_WIDTH'(qualified && agree);
    assign disagree_next = disagree_count + iagc_pkg::COUNT_WIDTH'(qualified && !agree);

    assign last = qualified
                  && samples == iagc_pkg::COUNT_WIDTH'(iagc_pkg::WINDOW_SAMPLES - 1);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state          <= iagc_pkg::DET_CLEAR;
            samples        <= '0;
            agree_count    <= '0;
            disagree_count <= '0;
            done           <= 1'b0;
            in_phase       <= 1'b0;
        end else if (i_status != iagc_pkg::IAGC_ADAPT) begin
            state          <= iagc_pkg::DET_CLEAR;
            samples        <= '0;
            agree_count    <= '0;
            disagree_count <= '0;
            done           <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                iagc_pkg::DET_CLEAR, iagc_pkg::DET_COUNT: begin
                    samples        <= samples + iagc_pkg::COUNT_WIDTH'(qualified);
                    agree_count    <= agree_next;
                    disagree_count <= disagree_next;
                    if (last) begin
                        state    <= iagc_pkg::DET_REPORT;
                        done     <= 1'b1;
                        in_phase <= agree_next >= disagree_next;  // ties count as in phase
                    end else if (qualified) begin
                        state <= iagc_pkg::DET_COUNT;
                    end
                end
                iagc_pkg::DET_REPORT: begin
                    state <= iagc_pkg::DET_REPORT;  // idle until status leaves adapt
                end
                default: begin
                    state <= iagc_pkg::DET_CLEAR;
                end
            endcase
        end
    end

    assign o_result = '{done: done, in_phase: in_phase};

endmodule

`default_nettype wire

// ==== logic/error_former.sv ====
`default_nettype none

module error_former (
    input  wire                                        i_clock,
    input  wire                                        i_arst_n,
    input  wire                                        i_sample,
    input  wire                                        i_gate,
    input  wire logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] i_input,
    input  wire logic signed [iagc_pkg::SAMPLE_WIDTH-1:0] i_reference,
    input  wire logic signed [iagc_pkg::WEIGHT_WIDTH-1:0] i_weight,
    output iagc_pkg::sample_t                          o_sample
);

    logic signed [iagc_pkg::PRODUCT_WIDTH-1:0] product;
    logic signed [iagc_pkg::PRODUCT_WIDTH-1:0] scaled;
    logic signed [iagc_pkg::DIFF_WIDTH-1:0]    diff;
    logic signed [iagc_pkg::SAMPLE_WIDTH-1:0]  error_sat;

    logic                                      valid_q;
    logic                                      gate_q;
    logic signed [iagc_pkg::SAMPLE_WIDTH-1:0]  reference_q;
    logic signed [iagc_pkg::SAMPLE_WIDTH-1:0]  error_q;

    assign product = i_weight * i_reference;
    assign scaled  = product >>> iagc_pkg::WEIGHT_FRAC;  // drop weight fraction
    assign diff    = iagc_pkg::DIFF_WIDTH'(i_input) - iagc_pkg::DIFF_WIDTH'(scaled);

    // clip to the sample range
    always_comb begin
        if (diff > iagc_pkg::DIFF_WIDTH'(iagc_pkg::SAMPLE_MAX)) begin
            error_sat = iagc_pkg::SAMPLE_MAX;
        end else if (diff < iagc_pkg::DIFF_WIDTH'(iagc_pkg::SAMPLE_MIN)) begin
            error_sat = iagc_pkg::SAMPLE_MIN;
        end else begin
            error_sat = diff[iagc_pkg::SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
            gate_q  <= 1'b0;
        end else begin
            valid_q <= i_sample;
            gate_q  <= i_gate;
        end
    end

    always_ff @(posedge i_clock) begin
        reference_q <= i_reference;  // kept aligned with the error
        error_q     <= error_sat;
    end

    assign o_sample = '{valid: valid_q, gate: gate_q, reference: reference_q, error: error_q};

endmodule

`default_nettype wire

// ==== logic/iagc_pkg.sv ====
`default_nettype none

package iagc_pkg;

    // sample and weight formats
    localparam int SAMPLE_WIDTH     = 14;
    localparam int WEIGHT_WIDTH     = 12;
    localparam int WEIGHT_FRAC      = 10;  // weight spans about -2 to +2
    localparam int WEIGHT_SUM_WIDTH = WEIGHT_WIDTH + 1;
    localparam int PRODUCT_WIDTH    = SAMPLE_WIDTH + WEIGHT_WIDTH;
    localparam int DIFF_WIDTH       = PRODUCT_WIDTH + 1;

    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MAX = 2 ** (SAMPLE_WIDTH - 1) - 1;
    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MIN = -(2 ** (SAMPLE_WIDTH - 1));
    localparam logic signed [WEIGHT_WIDTH-1:0] WEIGHT_MAX = 2 ** (WEIGHT_WIDTH - 1) - 1;
    localparam logic signed [WEIGHT_WIDTH-1:0] WEIGHT_MIN = -(2 ** (WEIGHT_WIDTH - 1));

    // decision window
    localparam int WINDOW_SAMPLES = 32;
    localparam int WINDOW_LOG2    = 5;
    localparam int COUNT_WIDTH    = WINDOW_LOG2 + 1;
    localparam int SUM_WIDTH      = SAMPLE_WIDTH + WINDOW_LOG2;

    localparam logic [SAMPLE_WIDTH-1:0] LEVEL_LOW_LIMIT  = 64;
    localparam logic [SAMPLE_WIDTH-1:0] LEVEL_HIGH_LIMIT = 1024;

    localparam logic signed [WEIGHT_WIDTH-1:0] STEP_FINE   = 2;
    localparam logic signed [WEIGHT_WIDTH-1:0] STEP_COARSE = 32;

    typedef enum logic [1:0] {IAGC_RESET, IAGC_INIT, IAGC_ADAPT} iagc_status_e;

    typedef enum logic [1:0] {LEVEL_LOW, LEVEL_MID, LEVEL_HIGH} level_e;

    // window states shared by both detectors
    typedef enum logic [1:0] {DET_CLEAR, DET_COUNT, DET_REPORT} det_state_e;

    typedef struct packed {
        logic                           valid;
        logic                           gate;
        logic signed [SAMPLE_WIDTH-1:0] reference;
        logic signed [SAMPLE_WIDTH-1:0] error;
    } sample_t;

    typedef struct packed {
        logic done;
        logic in_phase;
    } phase_result_t;

    typedef struct packed {
        logic   done;
        level_e level;
    } level_result_t;

endpackage

`default_nettype wire
